//--- cnn_fifo_delay.sv
`timescale 1ns/1ps

module cnn_fifo_delay #(
	parameter int DATA_WIDTH    = conv_cfg_pkg::DEF_DATA_WIDTH,
	parameter int DATA_DEPTH    = 4,
	parameter int POINTER_WIDTH = conv_cfg_pkg::ptr_width(DATA_DEPTH)
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   write,
	input  logic                   read,
	input  logic [DATA_WIDTH-1:0]  data_in,
	output logic [DATA_WIDTH-1:0]  data_out,
	output logic [POINTER_WIDTH:0] count,
	output logic                   full,
	output logic                   empty
);

	// Storage, no reset needed
	logic [DATA_WIDTH-1:0]    mem [DATA_DEPTH];
	logic [POINTER_WIDTH-1:0] wr_ptr;
	logic [POINTER_WIDTH-1:0] rd_ptr;
	logic                     do_write;
	logic                     do_read;

	// Overflow and underflow requests are dropped
	assign do_write = write && !full;
	assign do_read  = read && !empty;

	assign full  = (count == (POINTER_WIDTH + 1)'(DATA_DEPTH));
	assign empty = (count == '0);

	////////////////////////////////////////////////////////////
	// Pointers and occupancy
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// Wrap explicitly, depth need not be a power of two
			if (do_write) begin
				if (wr_ptr == POINTER_WIDTH'(DATA_DEPTH - 1))
					wr_ptr <= '0;
				else
					wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_read) begin
				if (rd_ptr == POINTER_WIDTH'(DATA_DEPTH - 1))
					rd_ptr <= '0;
				else
					rd_ptr <= rd_ptr + 1'b1;
			end
			// Simultaneous push and pop leaves count alone
			case ({do_write, do_read})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Write port and registered read port
	always_ff @(posedge clk) begin
		if (do_write)
			mem[wr_ptr] <= data_in;
		if (do_read)
			data_out <= mem[rd_ptr];
	end

endmodule

//--- conv_1x1_sva.sv
`timescale 1ns/1ps

module conv_1x1_sva (
	input logic                       clk,
	input logic                       reset,
	input conv_ctrl_pkg::ctrl_state_t state,
	input logic                       pixel_accept,
	input logic                       pop,
	input logic                       write,
	input logic                       weights_ready
);
	import conv_ctrl_pkg::*;

	// Pixels enter the PE array only with the whole set written
	a_accept_set_complete: assert property (@(posedge clk) disable iff (reset)
		pixel_accept |-> !pop && !write)
		else $error("pixel_accept high while a weight load is in flight");

	// Every PE write lands before the controller reports ready
	a_write_in_load: assert property (@(posedge clk) disable iff (reset)
		write |-> state == ST_LOAD)
		else $error("PE weight write outside ST_LOAD");

	// Reset clears the weight set
	a_ready_low_after_reset: assert property (@(posedge clk)
		reset |=> !weights_ready)
		else $error("weights_ready high after reset");

endmodule

bind conv_ctrl conv_1x1_sva u_conv_1x1_sva (
	.clk           (clk),
	.reset         (reset),
	.state         (state),
	.pixel_accept  (pixel_accept),
	.pop           (pop),
	.write         (write_q),
	.weights_ready (weights_ready)
);

//--- conv_1x1_top.sv
`timescale 1ns/1ps

module conv_1x1_top #(
	parameter int DATA_WIDTH = conv_cfg_pkg::DEF_DATA_WIDTH,
	parameter int C_IN       = conv_cfg_pkg::DEF_C_IN,
	parameter int C_OUT      = conv_cfg_pkg::DEF_C_OUT
) (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       weight_valid,
	input  logic [DATA_WIDTH-1:0]      weight_in,
	input  logic                       load_weights,
	input  logic                       pixel_valid,
	input  logic [C_IN*DATA_WIDTH-1:0] pixel_in,
	output logic                       weights_ready,
	output logic                       weight_full,
	output logic                       out_valid,
	output logic [C_OUT*conv_cfg_pkg::acc_width(DATA_WIDTH, C_IN)-1:0] out_data
);
	import conv_cfg_pkg::*;

	localparam int WEIGHT_NUM = weight_num(C_IN, C_OUT);

	// Controller gate into the PE pipeline
	logic pixel_accept;

	// Buffer, controller and PE array share the weight load bus
	weight_load_if #(
		.DATA_WIDTH (DATA_WIDTH),
		.WEIGHT_NUM (WEIGHT_NUM)
	) u_wl ();

	weight_buffer #(
		.DATA_WIDTH (DATA_WIDTH),
		.C_IN       (C_IN),
		.C_OUT      (C_OUT)
	) u_weight_buffer (
		.clk      (clk),
		.reset    (reset),
		.valid_in (weight_valid),
		.in       (weight_in),
		.full     (weight_full),
		.wl       (u_wl.buffer)
	);

	conv_ctrl #(
		.C_IN  (C_IN),
		.C_OUT (C_OUT)
	) u_conv_ctrl (
		.clk           (clk),
		.reset         (reset),
		.load_weights  (load_weights),
		.pixel_valid   (pixel_valid),
		.pixel_accept  (pixel_accept),
		.weights_ready (weights_ready),
		.wl            (u_wl.ctrl)
	);

	conv_pe_array #(
		.DATA_WIDTH (DATA_WIDTH),
		.C_IN       (C_IN),
		.C_OUT      (C_OUT)
	) u_conv_pe_array (
		.clk          (clk),
		.reset        (reset),
		.pixel_accept (pixel_accept),
		.pixel_in     (pixel_in),
		.wl           (u_wl.pe),
		.out_valid    (out_valid),
		.out_data     (out_data)
	);

endmodule

//--- conv_cfg_pkg.sv
package conv_cfg_pkg;

	////////////////////////////////////////////////////////////
	// Default data sizes
	////////////////////////////////////////////////////////////

	// Weight and pixel word width
	localparam int DEF_DATA_WIDTH = 16;
	// Channels in and out of the 1x1 kernel
	localparam int DEF_C_IN  = 2;
	localparam int DEF_C_OUT = 2;

	////////////////////////////////////////////////////////////
	// Derived sizes
	////////////////////////////////////////////////////////////

	// One weight per (output, input) channel pair
	function automatic int weight_num(input int c_in, input int c_out);
		return c_in * c_out;
	endfunction

	// Full product width, growth of the channel sum, plus one guard bit
	function automatic int acc_width(input int data_width, input int c_in);
		return 2 * data_width + $clog2(c_in) + 1;
	endfunction

	// Pointer into a FIFO of the given depth, never narrower than one bit
	function automatic int ptr_width(input int depth);
		return (depth > 1) ? $clog2(depth) : 1;
	endfunction

endpackage

//--- conv_ctrl.sv
`timescale 1ns/1ps

module conv_ctrl #(
	parameter int C_IN  = conv_cfg_pkg::DEF_C_IN,
	parameter int C_OUT = conv_cfg_pkg::DEF_C_OUT
) (
	input  logic        clk,
	input  logic        reset,
	input  logic        load_weights,
	input  logic        pixel_valid,
	output logic        pixel_accept,
	output logic        weights_ready,
	weight_load_if.ctrl wl
);
	import conv_cfg_pkg::*;
	import conv_ctrl_pkg::*;

	localparam int WEIGHT_NUM  = weight_num(C_IN, C_OUT);
	localparam int IDX_WIDTH   = ptr_width(WEIGHT_NUM);
	// Load phase runs WEIGHT_NUM pops plus two cycles for the write to land
	localparam int LCNT_WIDTH  = $clog2(WEIGHT_NUM + 2);

	ctrl_state_t           state;
	logic [LCNT_WIDTH-1:0] load_cnt;
	logic                  pop;
	logic                  write_q;
	logic                  load_ok;

	// Start a load only with a full set queued
	assign load_ok = load_weights && (int'(wl.count) >= WEIGHT_NUM);

	// Pop during the first WEIGHT_NUM load cycles
	assign pop    = (state == ST_LOAD) && (load_cnt < LCNT_WIDTH'(WEIGHT_NUM));
	assign wl.pop = pop;

	assign wl.write      = write_q;
	assign weights_ready = (state == ST_READY);
	// Pixels outside ST_READY are dropped
	assign pixel_accept  = pixel_valid && (state == ST_READY);

	////////////////////////////////////////////////////////////
	// Load sequencer
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= ST_IDLE;
			load_cnt <= '0;
			write_q  <= 1'b0;
		end else begin
			// FIFO data lands one cycle after the pop
			write_q <= pop;
			case (state)
				ST_IDLE, ST_READY: begin
					// Reload from ST_READY too, old set invalid at once
					if (load_ok) begin
						state    <= ST_LOAD;
						load_cnt <= '0;
					end
				end
				ST_LOAD: begin
					// Last write has landed by the final count
					if (load_cnt == LCNT_WIDTH'(WEIGHT_NUM + 1))
						state <= ST_READY;
					else
						load_cnt <= load_cnt + 1'b1;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Slot for the write that follows each pop
	always_ff @(posedge clk) begin
		if (pop)
			wl.index <= load_cnt[IDX_WIDTH-1:0];
	end

endmodule

//--- conv_ctrl_pkg.sv
package conv_ctrl_pkg;

	// Weight load sequencer states
	typedef enum logic [1:0] {
		// No valid weight set in the PE array
		ST_IDLE  = 2'd0,
		// Popping a set out of the weight FIFO
		ST_LOAD  = 2'd1,
		// Weight set complete, pixels accepted
		ST_READY = 2'd2
	} ctrl_state_t;

endpackage

//--- conv_pe_array.sv
`timescale 1ns/1ps

module conv_pe_array #(
	parameter int DATA_WIDTH = conv_cfg_pkg::DEF_DATA_WIDTH,
	parameter int C_IN       = conv_cfg_pkg::DEF_C_IN,
	parameter int C_OUT      = conv_cfg_pkg::DEF_C_OUT
) (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       pixel_accept,
	input  logic [C_IN*DATA_WIDTH-1:0] pixel_in,
	weight_load_if.pe                  wl,
	output logic                       out_valid,
	output logic [C_OUT*conv_cfg_pkg::acc_width(DATA_WIDTH, C_IN)-1:0] out_data
);
	import conv_cfg_pkg::*;

	localparam int WEIGHT_NUM = weight_num(C_IN, C_OUT);
	localparam int ACC_WIDTH  = acc_width(DATA_WIDTH, C_IN);
	localparam int PROD_WIDTH = 2 * DATA_WIDTH;

	// Weight bank, index k*C_IN+c
	logic signed [DATA_WIDTH-1:0] weight_reg [WEIGHT_NUM];
	// Stage 1, one product per weight
	logic signed [PROD_WIDTH-1:0] prod_q [WEIGHT_NUM];
	logic                         valid_q;
	// Stage 2 input
	logic signed [ACC_WIDTH-1:0]  sum_next [C_OUT];

	// Weight bank written by the controller
	always_ff @(posedge clk) begin
		if (wl.write)
			weight_reg[wl.index] <= wl.weight;
	end

	////////////////////////////////////////////////////////////
	// Stage 1, multiply
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (pixel_accept) begin
			for (int k = 0; k < C_OUT; k++) begin
				for (int c = 0; c < C_IN; c++) begin
					prod_q[k*C_IN+c] <= weight_reg[k*C_IN+c] *
						$signed(pixel_in[c*DATA_WIDTH +: DATA_WIDTH]);
				end
			end
		end
	end

	// Channel sums, sign extended to the accumulator width
	always_comb begin
		for (int k = 0; k < C_OUT; k++) begin
			sum_next[k] = '0;
			for (int c = 0; c < C_IN; c++)
				sum_next[k] = sum_next[k] + prod_q[k*C_IN+c];
		end
	end

	////////////////////////////////////////////////////////////
	// Stage 2, sum and output
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q   <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			valid_q   <= pixel_accept;
			out_valid <= valid_q;
		end
	end

	// Output channel k in slice k, channel 0 lowest
	always_ff @(posedge clk) begin
		if (valid_q) begin
			for (int k = 0; k < C_OUT; k++)
				out_data[k*ACC_WIDTH +: ACC_WIDTH] <= sum_next[k];
		end
	end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the conv_1x1 testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_conv_1x1 \
	-f verilog.f -o sim_conv_1x1 &&
./obj_dir/sim_conv_1x1 > sim.log 2>&1 || echo "Simulation run returned an error"
cat sim.log 2>/dev/null
grep -q "=== PASS ===" sim.log 2>/dev/null && echo "Simulation passed" ||
	{ echo "Simulation failed"; exit 1; }

//--- tb_conv_1x1.sv
`timescale 1ns/1ps

module tb_conv_1x1;
	import conv_cfg_pkg::*;

	localparam int DATA_WIDTH = DEF_DATA_WIDTH;
	localparam int C_IN       = DEF_C_IN;
	localparam int C_OUT      = DEF_C_OUT;
	localparam int WEIGHT_NUM = C_IN * C_OUT;
	localparam int ACC_WIDTH  = acc_width(DATA_WIDTH, C_IN);
	localparam int PIX_WIDTH  = C_IN * DATA_WIDTH;
	// Extra back-to-back pixels after the table
	localparam int N_RANDOM   = 12;

	typedef enum logic [1:0] {K_IDLE, K_WEIGHT, K_LOAD, K_PIXEL} step_kind_t;

	// One table row, expected status seen before the row's edge
	typedef struct packed {
		step_kind_t           kind;
		logic [PIX_WIDTH-1:0] operand;
		logic                 exp_ready;
		logic                 exp_full;
	} step_t;

	logic                         clk = 1'b0;
	logic                         reset;
	logic                         weight_valid;
	logic [DATA_WIDTH-1:0]        weight_in;
	logic                         load_weights;
	logic                         pixel_valid;
	logic [PIX_WIDTH-1:0]         pixel_in;
	logic                         weights_ready;
	logic                         weight_full;
	logic                         out_valid;
	logic [C_OUT*ACC_WIDTH-1:0]   out_data;

	step_t                        steps [$];
	step_t                        rnd_step;
	// Reference weight FIFO and the set held by the PE array
	logic signed [DATA_WIDTH-1:0] weight_q [$];
	logic signed [DATA_WIDTH-1:0] active [WEIGHT_NUM];
	// Expected sums, C_OUT entries per accepted pixel
	longint                       exp_q [$];
	longint                       exp_val;
	longint                       got_val;
	int                           errors = 0;
	int                           outputs = 0;
	int                           cycles = 0;
	int                           limit = 0;
	int                           seed = 52;

	conv_1x1_top #(
		.DATA_WIDTH (DATA_WIDTH),
		.C_IN       (C_IN),
		.C_OUT      (C_OUT)
	) u_conv_1x1_top (
		.clk           (clk),
		.reset         (reset),
		.weight_valid  (weight_valid),
		.weight_in     (weight_in),
		.load_weights  (load_weights),
		.pixel_valid   (pixel_valid),
		.pixel_in      (pixel_in),
		.weights_ready (weights_ready),
		.weight_full   (weight_full),
		.out_valid     (out_valid),
		.out_data      (out_data)
	);

	// 100 ns clock
	always #50 clk = ~clk;

	// Run limit
	always @(posedge clk) begin
		cycles++;
		if (limit > 0 && cycles >= limit) begin
			$display("Timeout after %0d cycles, outputs still pending", cycles);
			$display("=== FAIL ===");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	function automatic logic [PIX_WIDTH-1:0] pack_pixel(input int c0, input int c1);
		return {c1[DATA_WIDTH-1:0], c0[DATA_WIDTH-1:0]};
	endfunction

	// out k = sum over c of weight(k*C_IN+c) * pixel c
	task automatic push_expected(input logic [PIX_WIDTH-1:0] pix);
		longint sum;
		for (int k = 0; k < C_OUT; k++) begin
			sum = 0;
			for (int c = 0; c < C_IN; c++)
				sum += longint'(active[k*C_IN+c]) *
					longint'($signed(pix[c*DATA_WIDTH +: DATA_WIDTH]));
			exp_q.push_back(sum);
		end
	endtask

	task automatic add_step(input step_kind_t kind, input logic [PIX_WIDTH-1:0] op,
		input logic er, input logic ef);
		step_t s;
		s.kind      = kind;
		s.operand   = op;
		s.exp_ready = er;
		s.exp_full  = ef;
		steps.push_back(s);
	endtask

	// Drive one row and update the model
	task automatic apply_step(input step_t s);
		weight_valid = (s.kind == K_WEIGHT);
		weight_in    = s.operand[DATA_WIDTH-1:0];
		load_weights = (s.kind == K_LOAD);
		pixel_valid  = (s.kind == K_PIXEL);
		pixel_in     = s.operand;
		case (s.kind)
			// Full FIFO drops the word
			K_WEIGHT: begin
				if (weight_q.size() < WEIGHT_NUM)
					weight_q.push_back(s.operand[DATA_WIDTH-1:0]);
			end
			// Load needs a whole set queued
			K_LOAD: begin
				if (weight_q.size() >= WEIGHT_NUM) begin
					for (int i = 0; i < WEIGHT_NUM; i++)
						active[i] = weight_q.pop_front();
				end
			end
			// Accepted only while ready
			K_PIXEL: begin
				if (s.exp_ready)
					push_expected(s.operand);
			end
			default: ;
		endcase
	endtask

	task automatic check_status(input int idx, input step_t s);
		if (weights_ready !== s.exp_ready) begin
			$display("Error at %0t: weights_ready expected %0b, got %0b (step %0d)",
				$time, s.exp_ready, weights_ready, idx);
			errors++;
		end
		if (weight_full !== s.exp_full) begin
			$display("Error at %0t: weight_full expected %0b, got %0b (step %0d)",
				$time, s.exp_full, weight_full, idx);
			errors++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus table
	////////////////////////////////////////////////////////////
	task automatic build_table();
		// No weights yet, pixels dropped
		add_step(K_PIXEL, pack_pixel(3, 4), 0, 0);
		add_step(K_PIXEL, pack_pixel(-2, 5), 0, 0);
		// Half a set then a load pulse that must be ignored
		add_step(K_WEIGHT, 3, 0, 0);
		add_step(K_WEIGHT, -7, 0, 0);
		add_step(K_IDLE, 0, 0, 0);
		add_step(K_LOAD, 0, 0, 0);
		add_step(K_IDLE, 0, 0, 0);
		// Rest of the set, count lands two edges after each strobe
		add_step(K_WEIGHT, 12, 0, 0);
		add_step(K_WEIGHT, -1, 0, 0);
		add_step(K_IDLE, 0, 0, 0);
		add_step(K_IDLE, 0, 0, 1);
		add_step(K_LOAD, 0, 0, 1);
		// Load takes WEIGHT_NUM+2 cycles
		add_step(K_IDLE, 0, 0, 1);
		repeat (5)
			add_step(K_IDLE, 0, 0, 0);
		add_step(K_IDLE, 0, 1, 0);
		// Back-to-back pixels incl. extremes
		add_step(K_PIXEL, pack_pixel(3, 4), 1, 0);
		add_step(K_PIXEL, pack_pixel(-2, 5), 1, 0);
		add_step(K_PIXEL, pack_pixel(-32768, 32767), 1, 0);
		add_step(K_PIXEL, pack_pixel(-1, -1), 1, 0);
		add_step(K_IDLE, 0, 1, 0);
		// Five words into a four deep FIFO, last one lost
		add_step(K_WEIGHT, -32768, 1, 0);
		add_step(K_WEIGHT, 32767, 1, 0);
		add_step(K_WEIGHT, 5, 1, 0);
		add_step(K_WEIGHT, -9, 1, 0);
		add_step(K_WEIGHT, 1000, 1, 0);
		add_step(K_IDLE, 0, 1, 1);
		add_step(K_IDLE, 0, 1, 1);
		// Reload from ready, pixels in the load window dropped
		add_step(K_LOAD, 0, 1, 1);
		add_step(K_PIXEL, pack_pixel(7, 7), 0, 1);
		add_step(K_PIXEL, pack_pixel(-5, 9), 0, 0);
		add_step(K_IDLE, 0, 0, 0);
		add_step(K_PIXEL, pack_pixel(100, -100), 0, 0);
		add_step(K_IDLE, 0, 0, 0);
		add_step(K_PIXEL, pack_pixel(1, 1), 0, 0);
		// New set in use
		add_step(K_PIXEL, pack_pixel(-32768, -32768), 1, 0);
		add_step(K_PIXEL, pack_pixel(2, -3), 1, 0);
		add_step(K_IDLE, 0, 1, 0);
	endtask

	// Output compare, away from the driving edge
	always @(negedge clk) begin
		if (!reset && out_valid) begin
			if (exp_q.size() < C_OUT) begin
				$display("Error at %0t: out_valid high with no pixel accepted", $time);
				errors++;
			end else begin
				for (int k = 0; k < C_OUT; k++) begin
					exp_val = exp_q.pop_front();
					got_val = $signed(out_data[k*ACC_WIDTH +: ACC_WIDTH]);
					if (got_val != exp_val) begin
						$display("Error at %0t: out_data[%0d] expected %0d, got %0d",
							$time, k, exp_val, got_val);
						errors++;
					end
				end
				outputs++;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////
	initial begin
		reset        = 1'b1;
		weight_valid = 1'b0;
		weight_in    = '0;
		load_weights = 1'b0;
		pixel_valid  = 1'b0;
		pixel_in     = '0;
		build_table();
		limit = 10 * steps.size() + 100;
		repeat (4) @(posedge clk);
		#1 reset = 1'b0;
		foreach (steps[i]) begin
			@(posedge clk);
			#1;
			apply_step(steps[i]);
			check_status(i, steps[i]);
		end
		// Random pixels on the last loaded set
		repeat (N_RANDOM) begin
			@(posedge clk);
			#1;
			rnd_step.kind      = K_PIXEL;
			rnd_step.operand   = $random(seed);
			rnd_step.exp_ready = 1'b1;
			rnd_step.exp_full  = 1'b0;
			apply_step(rnd_step);
			check_status(-1, rnd_step);
		end
		@(posedge clk);
		#1;
		rnd_step = '0;
		apply_step(rnd_step);
		// Drain the pipeline, the run limit catches outputs that never come
		while (exp_q.size() != 0)
			@(negedge clk);
		// Room for a stray output behind the last one
		repeat (3) @(negedge clk);
		$display("Errors: %0d, outputs checked: %0d", errors, outputs);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- verilog.f
conv_cfg_pkg.sv
conv_ctrl_pkg.sv
weight_load_if.sv
cnn_fifo_delay.sv
weight_buffer.sv
conv_ctrl.sv
conv_pe_array.sv
conv_1x1_top.sv
conv_1x1_sva.sv
tb_conv_1x1.sv

//--- weight_buffer.sv
`timescale 1ns/1ps

module weight_buffer #(
	parameter int DATA_WIDTH = conv_cfg_pkg::DEF_DATA_WIDTH,
	parameter int C_IN       = conv_cfg_pkg::DEF_C_IN,
	parameter int C_OUT      = conv_cfg_pkg::DEF_C_OUT
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  valid_in,
	input  logic [DATA_WIDTH-1:0] in,
	output logic                  full,
	weight_load_if.buffer         wl
);
	import conv_cfg_pkg::*;

	// FIFO holds exactly one weight set
	localparam int WEIGHT_NUM    = weight_num(C_IN, C_OUT);
	localparam int POINTER_WIDTH = ptr_width(WEIGHT_NUM);

	logic                  in_valid_q;
	logic [DATA_WIDTH-1:0] in_data_q;

	////////////////////////////////////////////////////////////
	// Input register stage
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset)
			in_valid_q <= 1'b0;
		else
			in_valid_q <= valid_in;
	end

	// Payload only captured on a strobe
	always_ff @(posedge clk) begin
		if (valid_in)
			in_data_q <= in;
	end

	// Delay FIFO, popped by the controller
	cnn_fifo_delay #(
		.DATA_WIDTH    (DATA_WIDTH),
		.DATA_DEPTH    (WEIGHT_NUM),
		.POINTER_WIDTH (POINTER_WIDTH)
	) u_fifo (
		.clk      (clk),
		.reset    (reset),
		.write    (in_valid_q),
		.read     (wl.pop),
		.data_in  (in_data_q),
		.data_out (wl.weight),
		.count    (wl.count),
		.full     (full),
		.empty    ()
	);

endmodule

//--- weight_load_if.sv
`timescale 1ns/1ps

interface weight_load_if #(
	parameter int DATA_WIDTH = conv_cfg_pkg::DEF_DATA_WIDTH,
	parameter int WEIGHT_NUM = conv_cfg_pkg::weight_num(conv_cfg_pkg::DEF_C_IN,
		conv_cfg_pkg::DEF_C_OUT)
);
	import conv_cfg_pkg::*;

	// FIFO count covers 0..WEIGHT_NUM, index covers one weight set
	localparam int CNT_WIDTH = ptr_width(WEIGHT_NUM) + 1;
	localparam int IDX_WIDTH = ptr_width(WEIGHT_NUM);

	// FIFO read strobe
	logic                  pop;
	// Registered FIFO head, valid the cycle after pop
	logic [DATA_WIDTH-1:0] weight;
	// Weights currently queued
	logic [CNT_WIDTH-1:0]  count;
	// PE weight register write, with its slot
	logic                  write;
	logic [IDX_WIDTH-1:0]  index;

	modport buffer (
		input  pop,
		output weight,
		output count
	);

	modport ctrl (
		input  count,
		output pop,
		output write,
		output index
	);

	modport pe (
		input weight,
		input write,
		input index
	);

endinterface
